/* hw/serial_pkg.sv */
// line-level definitions for the three-wire shift engine
// word size, bit order, idle levels and the serial clock divider
// imported by clkgen, serial and anything that handles a raw serial word

package serial_pkg;

	// ------------------------------
	// word format
	// ------------------------------

	// bits per serial word
	localparam int WORD_BITS = 8;

	// one word as seen on the line
	typedef logic [WORD_BITS-1:0] word_t;

	// bit counter, one spare bit above the word index
	typedef logic [3:0] bitidx_t;

	// index into a word
	typedef logic [$clog2(WORD_BITS)-1:0] bitsel_t;

	// 0 sends the msb first
	localparam logic LOWBIT_FIRST = 1'b0;

	// ------------------------------
	// line levels and timing
	// ------------------------------

	// main clock cycles per serial half period
	localparam int CLK_DIV = 4;
	typedef logic [$clog2(CLK_DIV)-1:0] divcnt_t;

	// levels while no word is on the line
	localparam logic CLK_IDLE  = 1'b1;
	localparam logic DATA_IDLE = 1'b1;

	// shift engine states
	typedef enum logic {
		ready,
		transmit
	} serial_state_t;

endpackage

/* hw/regio_pkg.sv */
// register-access definitions shared by the host side of the master
// command format, operation codes and the frame sequencer states
// the serial line itself is described in serial_pkg

package regio_pkg;

	// ------------------------------
	// register space
	// ------------------------------

	// 7-bit register address
	localparam int ADDR_BITS = 7;
	typedef logic [ADDR_BITS-1:0] addr_t;

	// 8-bit register contents
	localparam int DATA_BITS = 8;
	typedef logic [DATA_BITS-1:0] data_t;

	// position of the read flag in the address word
	localparam int READ_FLAG = 7;

	// ------------------------------
	// host command
	// ------------------------------

	// operation requested by the host
	typedef enum logic {
		op_write = 1'b0,
		op_read  = 1'b1
	} op_t;

	// one command, 16 bits
	// data is ignored for a read
	typedef struct packed {
		op_t   op;
		addr_t addr;
		data_t data;
	} cmd_t;

	// ------------------------------
	// frame sequencing
	// ------------------------------

	// address word, then data word, then wait for the line to go idle
	typedef enum logic [1:0] {
		idle,
		addr_word,
		data_word,
		finish
	} decode_state_t;

endpackage

/* hw/clkgen.sv */
// serial clock divider
// toggles a clock level every CLK_DIV main cycles, starting high
// out_tick marks each falling edge and serves as the shift engine's clock enable

module clkgen (
	input  logic in_clk,
	input  logic in_rst,
	// divided clock level
	output logic out_sclk_level,
	// one cycle on every high-to-low toggle
	output logic out_tick
);
	import serial_pkg::*;

	// half period counter
	divcnt_t div_ctr;
	logic    wrap;

	// current level and falling-edge strobe
	logic level;
	logic tick;

	// end of a half period
	assign wrap = (div_ctr == divcnt_t'(CLK_DIV - 1));

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			div_ctr <= '0;
			level   <= 1'b1;
			tick    <= 1'b0;
		end else begin
			// tick only when the level drops
			tick <= wrap && level;
			if (wrap) begin
				div_ctr <= '0;
				level   <= ~level;
			end else begin
				div_ctr <= divcnt_t'(div_ctr + 1'b1);
			end
		end
	end

	// tick and the low level appear in the same cycle
	assign out_sclk_level = level;
	assign out_tick       = tick;

endmodule

/* hw/serial.sv */
// bit-serial shift engine for a three-wire port
// sends one word on out_serial and samples in_serial at the same bit position
// steps only on the falling-edge tick from clkgen
// out_next_word marks the last bit; keep in_enable high to chain the next word

module serial (
	input  logic              in_clk,
	input  logic              in_rst,
	// start or continue shifting
	input  logic              in_enable,
	// word to send, read while the counter is zero
	input  serial_pkg::word_t in_parallel,
	// last bit of a word is being taken
	output logic              out_next_word,
	// no word on the line
	output logic              out_ready,
	// word received from the device
	output serial_pkg::word_t out_parallel,
	// device pins
	output logic              out_clk,
	output logic              out_serial,
	input  logic              in_serial,
	output logic              out_sel
);
	import serial_pkg::*;

	// ------------------------------
	// serial clock
	// ------------------------------
	logic sclk_level;
	logic tick;

	clkgen u_clkgen (
		.in_clk         (in_clk),
		.in_rst         (in_rst),
		.out_sclk_level (sclk_level),
		.out_tick       (tick)
	);

	// ------------------------------
	// state and bit position
	// ------------------------------
	serial_state_t state;
	serial_state_t state_next;

	bitidx_t bit_ctr;
	bitidx_t bit_ctr_next;

	// counter mapped to a word index
	bitsel_t bit_sel;
	logic    last_bit;

	// shift buffers
	word_t tx_buf;
	word_t rx_buf;
	logic  tx_bit;

	assign bit_sel = LOWBIT_FIRST ? bitsel_t'(bit_ctr)
		: bitsel_t'(bitidx_t'(WORD_BITS - 1) - bit_ctr);
	assign last_bit = (bit_ctr == bitidx_t'(WORD_BITS - 1));

	// first bit comes straight from the input
	// buffer takes the word on the tick that leaves bit zero
	assign tx_bit = (bit_ctr == '0) ? in_parallel[bit_sel] : tx_buf[bit_sel];

	// ------------------------------
	// line outputs
	// ------------------------------
	assign out_clk       = (state == transmit) ? sclk_level : CLK_IDLE;
	assign out_serial    = (state == transmit) ? tx_bit : DATA_IDLE;
	// select low while a word is on the line
	assign out_sel       = ~(state == transmit);
	assign out_ready     = (state == ready);
	assign out_next_word = tick && (state == transmit) && last_bit;
	assign out_parallel  = rx_buf;

	// next state, taken only on a tick
	always_comb begin
		state_next   = state;
		bit_ctr_next = bit_ctr;
		case (state)
			ready: begin
				bit_ctr_next = '0;
				if (in_enable) begin
					state_next = transmit;
				end
			end
			transmit: begin
				// wrap at the end of each word
				if (last_bit) begin
					bit_ctr_next = '0;
				end else begin
					bit_ctr_next = bitidx_t'(bit_ctr + 1'b1);
				end
				// host stops after the current word
				if (!in_enable) begin
					state_next = ready;
				end
			end
			default: begin
				state_next = ready;
			end
		endcase
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state   <= ready;
			bit_ctr <= '0;
		end else if (tick) begin
			state   <= state_next;
			bit_ctr <= bit_ctr_next;
		end
	end

	// data buffers
	always_ff @(posedge in_clk) begin
		if (tick) begin
			if (bit_ctr == '0) begin
				tx_buf <= in_parallel;
			end
			// device bit for the period just ending
			if (state == transmit) begin
				rx_buf[bit_sel] <= in_serial;
			end
		end
	end

endmodule

/* hw/cmd_decode.sv */
// host command sequencer
// latches one command and feeds the shift engine an address word and a data word
// address word is the read flag over the 7-bit address; data word is zero for reads
// signals frame end once the engine is back in ready

module cmd_decode (
	input  logic              in_clk,
	input  logic              in_rst,
	// host command and strobe
	input  regio_pkg::cmd_t   in_cmd,
	input  logic              in_cmd_valid,
	// shift engine status
	input  logic              in_next_word,
	input  logic              in_ready,
	// shift engine control
	output logic              out_enable,
	output serial_pkg::word_t out_word,
	// frame status
	output logic              out_busy,
	output logic              out_is_read,
	output logic              out_frame_end
);
	import regio_pkg::*;
	import serial_pkg::*;

	decode_state_t state;
	decode_state_t state_next;

	// latched command
	cmd_t cmd_q;
	logic accept;

	// the two words of a frame
	word_t first_word;
	word_t second_word;

	// strobes while busy fall on the floor
	assign accept = (state == idle) && in_cmd_valid;

	always_comb begin
		first_word            = word_t'(cmd_q.addr);
		first_word[READ_FLAG] = (cmd_q.op == op_read);
	end
	assign second_word = (cmd_q.op == op_write) ? word_t'(cmd_q.data) : '0;

	// ------------------------------
	// engine side
	// ------------------------------
	assign out_word = (state == addr_word) ? first_word : second_word;
	// drop enable as soon as the last word ends
	assign out_enable = (state == addr_word) || ((state == data_word) && !in_next_word);

	assign out_busy      = (state != idle);
	assign out_is_read   = (cmd_q.op == op_read);
	assign out_frame_end = (state == finish) && in_ready;

	always_comb begin
		state_next = state;
		case (state)
			idle:      if (accept) state_next = addr_word;
			addr_word: if (in_next_word) state_next = data_word;
			data_word: if (in_next_word) state_next = finish;
			finish:    if (in_ready) state_next = idle;
			default:   state_next = idle;
		endcase
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	// command held for the whole frame
	always_ff @(posedge in_clk) begin
		if (accept) begin
			cmd_q <= in_cmd;
		end
	end

endmodule

/* hw/reply_collect.sv */
// result stage of the register master
// keeps the second received word of a read frame as the reply
// pulses done at each frame end and reply_valid only for reads

module reply_collect (
	input  logic              in_clk,
	input  logic              in_rst,
	// word boundaries and received word from the engine
	input  logic              in_next_word,
	input  serial_pkg::word_t in_rx_word,
	// frame info from the decoder
	input  logic              in_is_read,
	input  logic              in_frame_end,
	// host side
	output logic              out_done,
	output regio_pkg::data_t  out_reply,
	output logic              out_reply_valid
);
	import regio_pkg::*;

	// high during the second word
	logic second;
	// one cycle after the second word ends
	logic capture;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			second          <= 1'b0;
			capture         <= 1'b0;
			out_done        <= 1'b0;
			out_reply_valid <= 1'b0;
			out_reply       <= '0;
		end else begin
			// last bit is in the buffer by now
			capture <= in_next_word && second;
			if (in_frame_end) begin
				second <= 1'b0;
			end else if (in_next_word) begin
				second <= ~second;
			end
			// writes leave the last reply alone
			if (capture && in_is_read) begin
				out_reply <= data_t'(in_rx_word);
			end
			out_done        <= in_frame_end;
			out_reply_valid <= in_frame_end && in_is_read;
		end
	end

endmodule

/* hw/regio_master.sv */
// three-wire register-access master
// host gives one command per frame with a strobe, waits for done
// decode, shift engine and reply capture chained here

module regio_master (
	input  logic             in_clk,
	input  logic             in_rst,
	// host command port
	input  regio_pkg::cmd_t  in_cmd,
	input  logic             in_cmd_valid,
	output logic             out_busy,
	output logic             out_done,
	output regio_pkg::data_t out_reply,
	output logic             out_reply_valid,
	// device pins, select active low
	output logic             out_sclk,
	output logic             out_sdo,
	output logic             out_sel,
	input  logic             in_sdi
);
	import serial_pkg::*;

	// ------------------------------
	// decode to engine
	// ------------------------------
	logic  enable;
	word_t tx_word;
	logic  next_word;
	logic  ready;

	// engine and decode to result
	word_t rx_word;
	logic  is_read;
	logic  frame_end;

	cmd_decode u_decode (
		.in_clk        (in_clk),
		.in_rst        (in_rst),
		.in_cmd        (in_cmd),
		.in_cmd_valid  (in_cmd_valid),
		.in_next_word  (next_word),
		.in_ready      (ready),
		.out_enable    (enable),
		.out_word      (tx_word),
		.out_busy      (out_busy),
		.out_is_read   (is_read),
		.out_frame_end (frame_end)
	);

	serial u_serial (
		.in_clk        (in_clk),
		.in_rst        (in_rst),
		.in_enable     (enable),
		.in_parallel   (tx_word),
		.out_next_word (next_word),
		.out_ready     (ready),
		.out_parallel  (rx_word),
		.out_clk       (out_sclk),
		.out_serial    (out_sdo),
		.in_serial     (in_sdi),
		.out_sel       (out_sel)
	);

	reply_collect u_reply (
		.in_clk          (in_clk),
		.in_rst          (in_rst),
		.in_next_word    (next_word),
		.in_rx_word      (rx_word),
		.in_is_read      (is_read),
		.in_frame_end    (frame_end),
		.out_done        (out_done),
		.out_reply       (out_reply),
		.out_reply_valid (out_reply_valid)
	);

endmodule

/* verification/regio_master_sva.sv */
// protocol assertions for the register master top level
// bound onto every regio_master instance, reports only through failing assertions

module regio_master_sva (
	input logic in_clk,
	input logic in_rst,
	input logic out_busy,
	input logic out_done,
	input logic out_reply_valid,
	input logic out_sclk,
	input logic out_sel
);
	// rising serial edges inside the current frame
	logic [5:0] rise_cnt;
	logic       prev_sclk;
	logic       prev_sel;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			rise_cnt  <= '0;
			prev_sclk <= 1'b1;
			prev_sel  <= 1'b1;
		end else begin
			prev_sclk <= out_sclk;
			prev_sel  <= out_sel;
			if (!out_sel && out_sclk && !prev_sclk) begin
				rise_cnt <= rise_cnt + 6'd1;
			end else if (out_sel && prev_sel) begin
				rise_cnt <= '0;
			end
		end
	end

	// line idle whenever no frame is running
	idle_lines: assert property (@(posedge in_clk) disable iff (in_rst)
		!out_busy |-> (out_sel && out_sclk))
		else $error("select or serial clock not idle while not busy");

	// reply only together with done
	reply_with_done: assert property (@(posedge in_clk) disable iff (in_rst)
		out_reply_valid |-> out_done)
		else $error("reply valid outside a done cycle");

	done_pulse: assert property (@(posedge in_clk) disable iff (in_rst)
		out_done |=> !out_done)
		else $error("done longer than one cycle");

	// two words per frame
	sixteen_edges: assert property (@(posedge in_clk) disable iff (in_rst)
		$rose(out_sel) |-> (rise_cnt == 6'd16))
		else $error("frame without 16 rising serial clock edges");

endmodule

bind regio_master regio_master_sva u_sva (.*);

/* verification/regio_checker.sv */
// result checker for the register master testbench
// compares each done cycle against the expected reply from the testbench
// and keeps done and frame counts in step with accepted commands

module regio_checker (
	input  logic             clk,
	input  logic             rst,
	input  logic             done,
	input  logic             reply_valid,
	input  regio_pkg::data_t reply,
	// reply expected once the command in flight is done
	input  regio_pkg::data_t exp_reply,
	input  logic             exp_is_read,
	// bookkeeping from the testbench and device model
	input  int               accepted,
	input  int               frames,
	output int               error_count
);
	import regio_pkg::*;

	int done_count;

	initial begin
		error_count = 0;
		done_count  = 0;
	end

	// ------------------------------
	// per-cycle comparison
	// ------------------------------
	always @(posedge clk) begin
		if (!rst) begin
			if (reply_valid && !done) begin
				$display("reply valid seen outside a done cycle at %0t", $time);
				error_count++;
			end
			if (done) begin
				done_count++;
				// writes must stay silent
				if (reply_valid !== exp_is_read) begin
					$display("FAILED out_reply_valid expected %h got %h",
						exp_is_read, reply_valid);
					error_count++;
				end
				// writes keep the last read reply
				if (reply !== exp_reply) begin
					$display("FAILED out_reply expected %h got %h", exp_reply, reply);
					error_count++;
				end
				// one frame and one done per accepted command
				if (frames != accepted) begin
					$display("device saw %0d frames but %0d commands were accepted",
						frames, accepted);
					error_count++;
				end
				if (done_count != accepted) begin
					$display("%0d done pulses for %0d accepted commands",
						done_count, accepted);
					error_count++;
				end
			end
		end
	end

endmodule

/* verification/regio_master_tb.sv */
// testbench for the three-wire register master
// directed write/read checks, then 200 random commands against a device model
// checker module compares replies, bound assertions watch the line protocol

module regio_master_tb;
	import regio_pkg::*;

	localparam int TIMEOUT = 1000;

	logic  in_clk;
	logic  in_rst;
	cmd_t  in_cmd;
	logic  in_cmd_valid;
	logic  in_sdi = 1'b1;
	logic  out_busy;
	logic  out_done;
	logic  out_reply_valid;
	logic  out_sclk;
	logic  out_sdo;
	logic  out_sel;
	data_t out_reply;

	// reply expected once the command in flight is done
	data_t exp_reply;
	logic  exp_is_read;
	int    accepted;
	int    frames;
	int    chk_errors;
	int    dev_errors;
	int    seq_errors;
	logic  aborted;
	logic [31:0] seed;
	data_t shadow [128];

	regio_master UUT (.*);

	regio_checker u_checker (
		.clk         (in_clk),
		.rst         (in_rst),
		.done        (out_done),
		.reply_valid (out_reply_valid),
		.reply       (out_reply),
		.exp_reply   (exp_reply),
		.exp_is_read (exp_is_read),
		.accepted    (accepted),
		.frames      (frames),
		.error_count (chk_errors)
	);

	initial begin
		in_clk = 1'b0;
		forever #20 in_clk = ~in_clk;
	end

	// ------------------------------
	// device model
	// ------------------------------
	logic        dev_prev_sclk;
	logic        dev_prev_sel;
	logic [15:0] dev_shift;
	logic [7:0]  dev_addr_word;
	int          dev_rises;
	int          dev_falls;
	logic [7:0]  dev_mem [128];

	always @(posedge in_clk) begin
		if (in_rst) begin
			dev_prev_sclk <= 1'b1;
			dev_prev_sel  <= 1'b1;
			dev_rises     <= 0;
			dev_falls     <= 0;
			frames        <= 0;
			dev_errors    <= 0;
			in_sdi        <= 1'b1;
			for (int i = 0; i < 128; i++) dev_mem[i] <= 8'h00;
		end else begin
			dev_prev_sclk <= out_sclk;
			dev_prev_sel  <= out_sel;
			// device samples sdo on the rising edge
			if (!out_sel && out_sclk && !dev_prev_sclk) begin
				dev_shift <= {dev_shift[14:0], out_sdo};
				if (dev_rises == 7) dev_addr_word <= {dev_shift[6:0], out_sdo};
				dev_rises <= dev_rises + 1;
			end
			// next sdi bit after each falling edge, stored byte in the second word
			if (!out_sel && !out_sclk && dev_prev_sclk) begin
				if (dev_falls >= 8 && dev_falls <= 15) begin
					in_sdi <= dev_addr_word[7] & dev_mem[dev_addr_word[6:0]][15 - dev_falls];
				end else begin
					in_sdi <= 1'b0;
				end
				dev_falls <= dev_falls + 1;
			end
			// end of frame
			if (out_sel && !dev_prev_sel) begin
				if (dev_rises != 16) begin
					$display("device saw %0d serial clock edges in a frame", dev_rises);
					dev_errors <= dev_errors + 1;
				end
				if (!dev_addr_word[7]) dev_mem[dev_addr_word[6:0]] <= dev_shift[7:0];
				frames    <= frames + 1;
				dev_rises <= 0;
				dev_falls <= 0;
				in_sdi    <= 1'b1;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected reply from the shadow register file
	function automatic data_t ref_access(input cmd_t c);
		data_t r;
		r = '0;
		if (c.op == op_write) shadow[c.addr] = c.data;
		else r = shadow[c.addr];
		return r;
	endfunction

	// one command: strobe when idle, optional ignored strobe, wait for done
	task automatic run_cmd(input cmd_t c, input logic extra_strobe);
		int    cnt;
		data_t r;
		cnt = 0;
		while (out_busy && cnt < TIMEOUT) begin
			@(posedge in_clk);
			cnt++;
		end
		if (cnt >= TIMEOUT) begin
			$display("timeout waiting for the master to go idle");
			seq_errors++;
			aborted = 1'b1;
		end else begin
			in_cmd       <= c;
			in_cmd_valid <= 1'b1;
			@(posedge in_clk);
			in_cmd_valid <= 1'b0;
			accepted     <= accepted + 1;
			exp_is_read  <= (c.op == op_read);
			// reply register holds its value across writes
			r = ref_access(c);
			if (c.op == op_read) begin
				exp_reply <= r;
			end
			if (extra_strobe) begin
				repeat (4) @(posedge in_clk);
				in_cmd       <= ~c;
				in_cmd_valid <= 1'b1;
				@(posedge in_clk);
				in_cmd_valid <= 1'b0;
			end
			cnt = 0;
			while (!out_done && cnt < TIMEOUT) begin
				@(posedge in_clk);
				cnt++;
			end
			if (cnt >= TIMEOUT) begin
				$display("timeout waiting for out_done");
				seq_errors++;
				aborted = 1'b1;
			end
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		cmd_t c;
		in_rst       = 1'b1;
		in_cmd       = '0;
		in_cmd_valid = 1'b0;
		exp_reply    = '0;
		exp_is_read  = 1'b0;
		accepted     = 0;
		seq_errors   = 0;
		aborted      = 1'b0;
		seed         = 32'hbe09;
		for (int i = 0; i < 128; i++) shadow[i] = '0;
		repeat (16) @(posedge in_clk);
		in_rst <= 1'b0;
		@(posedge in_clk);
		@(posedge in_clk);
		// idle levels after reset
		if (out_busy !== 1'b0 || out_done !== 1'b0 || out_reply_valid !== 1'b0) begin
			$display("FAILED busy/done/reply_valid expected %h got %h", 3'h0,
				{out_busy, out_done, out_reply_valid});
			seq_errors++;
		end
		if (out_sel !== 1'b1 || out_sclk !== 1'b1 || out_sdo !== 1'b1) begin
			$display("FAILED sel/sclk/sdo expected %h got %h", 3'h7,
				{out_sel, out_sclk, out_sdo});
			seq_errors++;
		end
		if (out_reply !== 8'h00) begin
			$display("FAILED out_reply expected %h got %h", 8'h00, out_reply);
			seq_errors++;
		end
		// write and read back, then an unwritten register over a nonzero reply
		run_cmd('{op: op_write, addr: 7'h12, data: 8'ha5}, 1'b1);
		if (!aborted) run_cmd('{op: op_read, addr: 7'h12, data: 8'h00}, 1'b0);
		if (!aborted) run_cmd('{op: op_read, addr: 7'h55, data: 8'h00}, 1'b0);
		// random mix over a small address range for read hits
		for (int n = 0; n < 200 && !aborted; n++) begin
			seed = lcg_next(seed);
			c.op   = seed[31] ? op_read : op_write;
			c.addr = addr_t'({2'b00, seed[20:16]});
			c.data = seed[15:8];
			run_cmd(c, (n % 7) == 3);
		end
		repeat (4) @(posedge in_clk);
		$display("errors: checker %0d, device %0d, sequence %0d",
			chk_errors, dev_errors, seq_errors);
		if (chk_errors == 0 && dev_errors == 0 && seq_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog.f */
hw/serial_pkg.sv
hw/regio_pkg.sv
hw/clkgen.sv
hw/serial.sv
hw/cmd_decode.sv
hw/reply_collect.sv
hw/regio_master.sv
verification/regio_master_sva.sv
verification/regio_checker.sv
verification/regio_master_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = regio_master_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
